//--- verilog/nandSyncDataOut_settings.svh
`ifndef NAND_SYNC_DATA_OUT_SETTINGS_SVH
`define NAND_SYNC_DATA_OUT_SETTINGS_SVH

// channel geometry
`define NAND_NUM_WAYS           4

// timing, in system clock cycles
`define NAND_TDQSS_CYCLES       4   // select to first data
`define NAND_TWPST_CYCLES       3   // write postamble

`define NAND_BYTES_PER_BEAT     2   // one 16-bit word per beat

// pad codes
`define NAND_STROBE_BEAT        8'b0000_1100
`define NAND_LATCH_DATA         4'b0011     // ALE/CLE during data out
`define NAND_WE_IDLE            4'b0011
`define NAND_WE_ACTIVE          4'b0010

`endif

//--- verilog/nandSyncDataOutPkg.sv
package nandSyncDataOutPkg;

    typedef logic [3:0]  wayMaskT;      // one bit per way
    typedef logic [7:0]  chipEnableT;   // active low, two per way
    typedef logic [15:0] byteCountT;
    typedef logic [15:0] writeWordT;
    typedef logic [31:0] padDataT;      // DQ pad bus
    typedef logic [7:0]  strobeT;       // DQS pattern
    typedef logic [3:0]  laneCtrlT;     // per-lane WE/ALE/CLE
    typedef logic [3:0]  timerT;

    // data-out sequencer
    typedef enum logic [2:0] {
        reset,
        ready,
        latch,
        dqssWait,
        waitValid,
        beat,
        postamble
    } seqStateT;

endpackage

//--- verilog/nandPadIf.sv
`timescale 1ns/1ps

// pad values from the sequencer, before alignment
interface nandPadIf;

    nandSyncDataOutPkg::padDataT    dq;
    nandSyncDataOutPkg::strobeT     dqStrobe;
    nandSyncDataOutPkg::chipEnableT chipEnable;
    nandSyncDataOutPkg::laneCtrlT   writeEnable;
    nandSyncDataOutPkg::laneCtrlT   addressLatchEnable;
    nandSyncDataOutPkg::laneCtrlT   commandLatchEnable;

    modport source (
        output dq, dqStrobe, chipEnable, writeEnable, addressLatchEnable, commandLatchEnable
    );

    modport sink (
        input dq, dqStrobe, chipEnable, writeEnable, addressLatchEnable, commandLatchEnable
    );

endinterface

//--- verilog/nandDataOutSequencer.sv
`timescale 1ns/1ps
`include "nandSyncDataOut_settings.svh"

module nandDataOutSequencer (
    input  logic                          iSystemClock,
    input  logic                          reset,
    input  logic                          start,
    input  nandSyncDataOutPkg::wayMaskT   targetWay,
    input  nandSyncDataOutPkg::byteCountT numOfData,
    input  nandSyncDataOutPkg::writeWordT writeData,
    input  logic                          writeValid,
    output logic                          ready,
    output logic                          lastStep,
    output logic                          writeReady,
    nandPadIf.source                      pad
);

    nandSyncDataOutPkg::seqStateT  state;
    nandSyncDataOutPkg::seqStateT  nextState;
    nandSyncDataOutPkg::wayMaskT   wayMask;     // latched at start
    nandSyncDataOutPkg::byteCountT byteLimit;
    nandSyncDataOutPkg::byteCountT byteCount;   // bytes taken so far
    nandSyncDataOutPkg::byteCountT countNext;
    nandSyncDataOutPkg::timerT     timer;       // tDQSS and postamble share it
    logic                          acceptBeat;
    logic                          finalBeat;
    logic                          transferDone;
    logic                          dqssDone;
    logic                          postambleEnd;
    logic                          waysSelected;

    assign acceptBeat   = writeValid & writeReady;
    assign countNext    = byteCount + nandSyncDataOutPkg::byteCountT'(`NAND_BYTES_PER_BEAT);
    assign finalBeat    = acceptBeat && (countNext == byteLimit);
    assign transferDone = (byteCount == byteLimit);
    assign dqssDone     = (timer == nandSyncDataOutPkg::timerT'(`NAND_TDQSS_CYCLES - 1));
    assign postambleEnd = (timer == nandSyncDataOutPkg::timerT'(`NAND_TWPST_CYCLES - 1));

    // chips stay selected from the tDQSS wait until ready returns
    assign waysSelected = (nextState != nandSyncDataOutPkg::reset) &&
                          (nextState != nandSyncDataOutPkg::ready) &&
                          (nextState != nandSyncDataOutPkg::latch);

    always_ff @(posedge iSystemClock) begin
        if (reset) begin
            state <= nandSyncDataOutPkg::reset;
        end else begin
            state <= nextState;
        end
    end

    always_comb begin
        nextState = state;
        case (state)
            nandSyncDataOutPkg::reset: begin
                nextState = nandSyncDataOutPkg::ready;
            end
            nandSyncDataOutPkg::ready: begin
                if (start) begin
                    nextState = nandSyncDataOutPkg::latch;
                end
            end
            nandSyncDataOutPkg::latch: begin
                nextState = nandSyncDataOutPkg::dqssWait;
            end
            nandSyncDataOutPkg::dqssWait: begin
                if (dqssDone) begin
                    nextState = nandSyncDataOutPkg::waitValid;
                end
            end
            nandSyncDataOutPkg::waitValid: begin
                if (acceptBeat) begin
                    nextState = nandSyncDataOutPkg::beat;
                end
            end
            nandSyncDataOutPkg::beat: begin
                // back-to-back words keep us here
                if (acceptBeat) begin
                    nextState = nandSyncDataOutPkg::beat;
                end else if (transferDone) begin
                    nextState = nandSyncDataOutPkg::postamble;
                end else begin
                    nextState = nandSyncDataOutPkg::waitValid;
                end
            end
            nandSyncDataOutPkg::postamble: begin
                if (lastStep) begin
                    nextState = nandSyncDataOutPkg::ready;
                end
            end
            default: begin
                nextState = nandSyncDataOutPkg::ready;
            end
        endcase
    end

    // handshake, counters and timer
    always_ff @(posedge iSystemClock) begin
        if (reset) begin
            ready      <= 1'b0;
            lastStep   <= 1'b0;
            writeReady <= 1'b0;
            byteCount  <= '0;
            timer      <= '0;
        end else begin
            ready      <= (nextState == nandSyncDataOutPkg::ready);
            lastStep   <= (state == nandSyncDataOutPkg::postamble) && postambleEnd;
            writeReady <= ((nextState == nandSyncDataOutPkg::waitValid) ||
                           (nextState == nandSyncDataOutPkg::beat)) && !finalBeat;

            if (nextState == nandSyncDataOutPkg::latch) begin
                byteCount <= '0;
            end else if (acceptBeat) begin
                byteCount <= countNext;
            end

            if ((state == nandSyncDataOutPkg::dqssWait) ||
                (state == nandSyncDataOutPkg::postamble)) begin
                timer <= timer + 1'b1;
            end else begin
                timer <= '0;
            end
        end
    end

    always_ff @(posedge iSystemClock) begin
        if (nextState == nandSyncDataOutPkg::latch) begin
            wayMask   <= targetWay;
            byteLimit <= numOfData;
        end
    end

    // pad values, one cycle after the accepting edge
    always_ff @(posedge iSystemClock) begin
        if (reset) begin
            pad.dq                 <= '0;
            pad.dqStrobe           <= '0;
            pad.chipEnable         <= {(2 * `NAND_NUM_WAYS){1'b1}};
            pad.writeEnable        <= `NAND_WE_IDLE;
            pad.addressLatchEnable <= '0;
            pad.commandLatchEnable <= '0;
        end else begin
            if (acceptBeat) begin
                pad.dq                 <= {{2{writeData[15:8]}}, {2{writeData[7:0]}}};
                pad.dqStrobe           <= `NAND_STROBE_BEAT;
                pad.addressLatchEnable <= `NAND_LATCH_DATA;
                pad.commandLatchEnable <= `NAND_LATCH_DATA;
            end else begin
                pad.dqStrobe           <= '0;       // dq keeps the last word
                pad.addressLatchEnable <= '0;
                pad.commandLatchEnable <= '0;
            end

            if (waysSelected) begin
                pad.chipEnable <= {2{~wayMask}};
            end else begin
                pad.chipEnable <= {(2 * `NAND_NUM_WAYS){1'b1}};
            end

            pad.writeEnable <= `NAND_WE_ACTIVE;     // idle code only until first ready
        end
    end

endmodule

//--- verilog/nandPadPipeline.sv
`timescale 1ns/1ps

module nandPadPipeline (
    input  logic                           iSystemClock,
    nandPadIf.sink                         pad,
    output nandSyncDataOutPkg::strobeT     dqStrobe,
    output nandSyncDataOutPkg::padDataT    dq,
    output nandSyncDataOutPkg::chipEnableT chipEnable,
    output nandSyncDataOutPkg::laneCtrlT   writeEnable,
    output nandSyncDataOutPkg::laneCtrlT   addressLatchEnable,
    output nandSyncDataOutPkg::laneCtrlT   commandLatchEnable
);

    nandSyncDataOutPkg::padDataT dqStage;   // first DQ stage

    // DQS lags the sequencer by one cycle
    always_ff @(posedge iSystemClock) begin
        dqStrobe <= pad.dqStrobe;
    end

    // DQ lags by two, so the data eye
    // sits centered on the strobe edges from the pad cells
    always_ff @(posedge iSystemClock) begin
        dqStage <= pad.dq;
        dq      <= dqStage;
    end

    // control lanes go straight out
    assign chipEnable         = pad.chipEnable;
    assign writeEnable        = pad.writeEnable;
    assign addressLatchEnable = pad.addressLatchEnable;
    assign commandLatchEnable = pad.commandLatchEnable;

endmodule

//--- verilog/nandSyncDataOut.sv
`timescale 1ns/1ps

module nandSyncDataOut (
    input  logic                           iSystemClock,
    input  logic                           reset,

    input  logic                           start,
    input  nandSyncDataOutPkg::wayMaskT    targetWay,
    input  nandSyncDataOutPkg::byteCountT  numOfData,
    output logic                           ready,
    output logic                           lastStep,

    input  nandSyncDataOutPkg::writeWordT  writeData,
    input  logic                           writeLast,   // unused, byte count ends the transfer
    input  logic                           writeValid,
    output logic                           writeReady,

    output nandSyncDataOutPkg::strobeT     dqStrobe,
    output nandSyncDataOutPkg::padDataT    dq,
    output nandSyncDataOutPkg::chipEnableT chipEnable,
    output nandSyncDataOutPkg::laneCtrlT   writeEnable,
    output nandSyncDataOutPkg::laneCtrlT   addressLatchEnable,
    output nandSyncDataOutPkg::laneCtrlT   commandLatchEnable
);

    nandPadIf padBus ();

    nandDataOutSequencer sequencer (
        .iSystemClock (iSystemClock),
        .reset        (reset),
        .start        (start),
        .targetWay    (targetWay),
        .numOfData    (numOfData),
        .writeData    (writeData),
        .writeValid   (writeValid),
        .ready        (ready),
        .lastStep     (lastStep),
        .writeReady   (writeReady),
        .pad          (padBus.source)
    );

    // aligns DQS and DQ to the pad timing
    nandPadPipeline padPipeline (
        .iSystemClock       (iSystemClock),
        .pad                (padBus.sink),
        .dqStrobe           (dqStrobe),
        .dq                 (dq),
        .chipEnable         (chipEnable),
        .writeEnable        (writeEnable),
        .addressLatchEnable (addressLatchEnable),
        .commandLatchEnable (commandLatchEnable)
    );

endmodule

//--- verif/nandSyncDataOut_checker.sv
`timescale 1ns/1ps
`include "nandSyncDataOut_settings.svh"

module nandSyncDataOut_checker (
    input logic                         iSystemClock,
    input logic                         reset,
    input logic                         ready,
    input logic                         writeReady,
    input logic                         lastStep,
    input nandSyncDataOutPkg::strobeT   dqStrobe,
    input nandSyncDataOutPkg::laneCtrlT addressLatchEnable
);

    readyExclusive: assert property (@(posedge iSystemClock) disable iff (reset)
        !(ready && writeReady))
        else $error("ready and writeReady high in the same cycle");

    lastStepSingle: assert property (@(posedge iSystemClock) disable iff (reset)
        lastStep |=> !lastStep)
        else $error("lastStep held for more than one cycle");

    // ALE leads the registered strobe by one cycle
    aleWithStrobe: assert property (@(posedge iSystemClock) disable iff (reset)
        (dqStrobe != `NAND_STROBE_BEAT) |-> ($past(addressLatchEnable) == '0))
        else $error("ALE active without a data beat on the strobe");

endmodule

bind nandSyncDataOut nandSyncDataOut_checker protocolCheck (
    .iSystemClock       (iSystemClock),
    .reset              (reset),
    .ready              (ready),
    .writeReady         (writeReady),
    .lastStep           (lastStep),
    .dqStrobe           (dqStrobe),
    .addressLatchEnable (addressLatchEnable)
);

//--- verif/nandSyncDataOutTb.sv
`timescale 1ns/1ps
`include "nandSyncDataOut_settings.svh"

module nandSyncDataOutTb;

    localparam int maxCycles = 200;

    logic                           iSystemClock;
    logic                           reset;
    logic                           start;
    nandSyncDataOutPkg::wayMaskT    targetWay;
    nandSyncDataOutPkg::byteCountT  numOfData;
    nandSyncDataOutPkg::writeWordT  writeData;
    logic                           writeLast;
    logic                           writeValid;
    logic                           ready;
    logic                           lastStep;
    logic                           writeReady;
    nandSyncDataOutPkg::strobeT     dqStrobe;
    nandSyncDataOutPkg::padDataT    dq;
    nandSyncDataOutPkg::chipEnableT chipEnable;
    nandSyncDataOutPkg::laneCtrlT   writeEnable;
    nandSyncDataOutPkg::laneCtrlT   addressLatchEnable;
    nandSyncDataOutPkg::laneCtrlT   commandLatchEnable;
    logic [31:0]                    lcgState;

    nandSyncDataOut nandSyncDataOut_i (.*);

    initial begin
        iSystemClock = 1'b0;
        forever #5 iSystemClock = ~iSystemClock;
    end

    function automatic logic [31:0] nextRandom();
        lcgState = lcgState * 32'd1664525 + 32'd1013904223;
        return lcgState;
    endfunction

    // high byte on both upper lanes, low byte on both lower lanes
    function automatic logic [31:0] dqFromWord(input nandSyncDataOutPkg::writeWordT word);
        return {word[15:8], word[15:8], word[7:0], word[7:0]};
    endfunction

    task automatic reportFailure();
        $display("Result: FAILED");
        $fatal(1, "stopped at first error");
    endtask

    task automatic compareValue(input string name, input logic [31:0] actual,
                                input logic [31:0] expected);
        if (actual !== expected) begin
            $display("Mismatch at %0t: %s is %h, expected %h", $time, name, actual, expected);
            reportFailure();
        end
    endtask

    task automatic checkResetAndIdle();
        int cycles;

        cycles = 0;
        repeat (5) @(posedge iSystemClock);
        compareValue("ready", 32'(ready), 32'd0);
        compareValue("lastStep", 32'(lastStep), 32'd0);
        compareValue("writeReady", 32'(writeReady), 32'd0);
        compareValue("dqStrobe", 32'(dqStrobe), 32'd0);
        compareValue("dq", dq, 32'd0);
        compareValue("chipEnable", 32'(chipEnable), 32'hff);
        compareValue("addressLatchEnable", 32'(addressLatchEnable), 32'd0);
        compareValue("commandLatchEnable", 32'(commandLatchEnable), 32'd0);
        reset <= 1'b0;
        while (ready !== 1'b1) begin
            compareValue("writeEnable", 32'(writeEnable), 32'(`NAND_WE_IDLE));
            @(posedge iSystemClock);
            cycles++;
            if (cycles > maxCycles) begin
                $display("Timeout: ready never rose after reset");
                reportFailure();
            end
        end
        compareValue("writeEnable", 32'(writeEnable), 32'(`NAND_WE_ACTIVE));
    endtask

    // one transfer, from start until ready returns
    task automatic runTransfer(input nandSyncDataOutPkg::wayMaskT mask, input int numBytes,
                               input bit holdValid);
        nandSyncDataOutPkg::writeWordT words[$];
        nandSyncDataOutPkg::writeWordT wordHist[3];
        nandSyncDataOutPkg::padDataT   seen[$];
        logic [31:0]                   randomValue;
        logic [2:0]                    acceptHist;  // bit n is the accept n+1 edges back
        logic                          accepted;
        logic                          prevLastStep;
        logic                          prevStrobeBeat;
        int                            numWords;
        int                            sent;
        int                            lastSteps;
        int                            cycles;

        numWords = numBytes / `NAND_BYTES_PER_BEAT;
        for (int i = 0; i < numWords; i++) begin
            randomValue = nextRandom();
            words.push_back(randomValue[31:16]);
        end
        acceptHist = '0;
        prevLastStep = 1'b0;
        prevStrobeBeat = 1'b0;
        sent = 0;
        lastSteps = 0;
        cycles = 0;
        start     <= 1'b1;
        targetWay <= mask;
        numOfData <= 16'(numBytes);
        @(posedge iSystemClock);
        start <= 1'b0;
        do begin
            @(posedge iSystemClock);
            cycles++;
            if (cycles > maxCycles) begin
                $display("Timeout: transfer did not return to ready");
                reportFailure();
            end
            accepted = writeValid && writeReady;
            if (ready) begin
                compareValue("lastStep before ready", 32'(prevLastStep), 32'd1);
                compareValue("chipEnable", 32'(chipEnable), 32'hff);
            end else if (cycles >= 2) begin
                compareValue("chipEnable", 32'(chipEnable), 32'({2{~mask}}));
            end
            if (sent == numWords) begin
                compareValue("writeReady", 32'(writeReady), 32'd0);  // nothing owed any more
            end
            compareValue("dqStrobe", 32'(dqStrobe),
                         acceptHist[1] ? 32'(`NAND_STROBE_BEAT) : 32'd0);
            compareValue("addressLatchEnable", 32'(addressLatchEnable),
                         acceptHist[0] ? 32'(`NAND_LATCH_DATA) : 32'd0);
            compareValue("commandLatchEnable", 32'(commandLatchEnable),
                         acceptHist[0] ? 32'(`NAND_LATCH_DATA) : 32'd0);
            if (acceptHist[2]) begin
                compareValue("dq", dq, dqFromWord(wordHist[2]));
            end
            if (prevStrobeBeat) begin
                seen.push_back(dq);
            end
            if (lastStep) begin
                lastSteps++;
            end
            acceptHist = {acceptHist[1:0], accepted};
            wordHist[2] = wordHist[1];
            wordHist[1] = wordHist[0];
            wordHist[0] = writeData;
            prevStrobeBeat = (dqStrobe == `NAND_STROBE_BEAT);
            prevLastStep = lastStep;
            if (accepted) begin
                sent++;
            end
            if (sent < numWords) begin
                randomValue = nextRandom();
                writeData  <= words[sent];
                writeLast  <= (sent == numWords - 1);
                writeValid <= holdValid || randomValue[16];  // random gaps
            end else begin
                writeValid <= 1'b0;
                writeLast  <= 1'b0;
            end
        end while (ready !== 1'b1);
        compareValue("lastStep pulses", 32'(lastSteps), 32'd1);
        compareValue("accepted beats", 32'(sent), 32'(numWords));
        compareValue("strobe aligned words", 32'(seen.size()), 32'(numWords));
        foreach (seen[i]) begin
            compareValue("strobe aligned dq", seen[i], dqFromWord(words[i]));
        end
    endtask

    initial begin
        lcgState = 32'hfc723cc2;
        reset = 1'b1;
        start = 1'b0;
        targetWay = '0;
        numOfData = '0;
        writeData = '0;
        writeLast = 1'b0;
        writeValid = 1'b0;
        checkResetAndIdle();
        runTransfer(4'b0001, 8, 1'b1);
        runTransfer(4'b0100, 8, 1'b1);
        runTransfer(4'b1011, 8, 1'b1);
        runTransfer(4'b0100, 8, 1'b0);
        runTransfer(4'b1011, 16, 1'b0);  // started right as ready returns
        $display("Result: PASSED");
        $finish;
    end

endmodule

//--- nandSyncDataOut.f
+incdir+verilog
verilog/nandSyncDataOutPkg.sv
verilog/nandPadIf.sv
verilog/nandDataOutSequencer.sv
verilog/nandPadPipeline.sv
verilog/nandSyncDataOut.sv
verif/nandSyncDataOut_checker.sv
verif/nandSyncDataOutTb.sv

//--- runSim.sh
#!/bin/sh
# build with Verilator, run, and decide pass or fail from the log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing --assert -Wno-fatal --top-module nandSyncDataOutTb \
    -f nandSyncDataOut.f -o simv || exit 1
./obj_dir/simv > sim.log 2>&1
cat sim.log
grep -q "Result: PASSED" sim.log && echo "simulation ok" || { echo "simulation failed"; exit 1; }
